/* verilog/io_bus_pkg.sv */
`default_nettype none

package io_bus_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// register map
	localparam addr_t P1_ADDR   = 8'h00; // pad select / column readback
	localparam addr_t TEST_ADDR = 8'h60; // bit 0 enables pin test mode

	// nothing drives the data bus on an unmapped read
	localparam data_t OPEN_BUS_DATA = 8'hff;

	// fixed bits in the read views
	localparam logic [1:0] P1_HI_ONES   = 2'b11; // p1 bits 7:6
	localparam logic [6:0] TEST_HI_ONES = 7'h7f; // test reg bits 7:1

endpackage

`default_nettype wire

/* verilog/joypad_pkg.sv */
`default_nettype none

package joypad_pkg;

	localparam int COL_W = 4;
	localparam int SEL_W = 2;

	// p10..p13, low when a key in a selected row is down
	typedef logic [COL_W-1:0] col_t;

	// bit 0 = p14 directions, bit 1 = p15 buttons, low selects
	typedef logic [SEL_W-1:0] sel_t;

	typedef struct packed {
		sel_t       sel;
		logic       test_mode;
		col_t       test_cols; // p1 bits 3:0
		logic       test_sout; // p1 bit 6
		logic       test_sin;  // p1 bit 7
	} pad_ctrl_t;

	localparam sel_t SEL_NONE  = 2'b11; // no row driven
	localparam col_t COLS_IDLE = 4'hf;  // pulled up, no key

	// column input synchronizer
	localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

/* verilog/io_bus_if.sv */
`default_nettype none

interface io_bus_if
	import io_bus_pkg::*;
	();

	logic  sel;   // one-cycle access strobe
	logic  wr;
	addr_t addr;
	data_t wdata;
	data_t rdata; // combinational from target

	modport slave (
		output sel,
		output wr,
		output addr,
		output wdata,
		input  rdata
	);

	modport target (
		input  sel,
		input  wr,
		input  addr,
		input  wdata,
		output rdata
	);

endinterface

`default_nettype wire

/* verilog/io_bus_slave.sv */
`default_nettype none

module io_bus_slave
	import io_bus_pkg::*;
	(
		input  logic  clk,
		input  logic  rst_n,

		input  logic  req,
		input  logic  we,
		input  addr_t addr,
		input  data_t wdata,
		output logic  ack,
		output data_t rdata,

		io_bus_if.slave bus
	);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_WAIT_REL
	} state_t;

	state_t state;
	logic   start;
	logic   sel_q;
	logic   we_q;
	addr_t  addr_q;
	data_t  wdata_q;
	data_t  rdata_q;

	assign start = (state == ST_IDLE) && req;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			sel_q <= 1'b0;
			ack   <= 1'b0;
		end else begin
			sel_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req) begin
						state <= ST_ACCESS;
						sel_q <= 1'b1; // single strobe per handshake
					end
				end
				ST_ACCESS: begin
					state <= ST_WAIT_REL;
					ack   <= 1'b1;
				end
				ST_WAIT_REL: begin
					if (!req) begin
						state <= ST_IDLE;
						ack   <= 1'b0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			addr_q  <= addr;
			we_q    <= we;
			wdata_q <= wdata;
		end
		if (state == ST_ACCESS)
			rdata_q <= bus.rdata; // held until the next access
	end

	assign bus.sel   = sel_q;
	assign bus.wr    = we_q;
	assign bus.addr  = addr_q;
	assign bus.wdata = wdata_q;
	assign rdata     = rdata_q;

endmodule

`default_nettype wire

/* verilog/joypad_regs.sv */
`default_nettype none

module joypad_regs
	import io_bus_pkg::*;
	import joypad_pkg::*;
	(
		input  logic      clk,
		input  logic      rst_n,

		io_bus_if.target  bus,

		input  col_t      col_sync,
		output pad_ctrl_t pad_ctrl
	);

	pad_ctrl_t ctrl_q;
	logic      wr_en;
	data_t     p1_view;
	data_t     test_view;

	assign wr_en = bus.sel && bus.wr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q.sel       <= SEL_NONE;
			ctrl_q.test_mode <= 1'b0;
			ctrl_q.test_cols <= COLS_IDLE;
			ctrl_q.test_sout <= 1'b1;
			ctrl_q.test_sin  <= 1'b1;
		end else if (wr_en) begin
			case (bus.addr)
				P1_ADDR: begin
					ctrl_q.sel       <= bus.wdata[5:4];
					ctrl_q.test_cols <= bus.wdata[3:0];
					ctrl_q.test_sout <= bus.wdata[6];
					ctrl_q.test_sin  <= bus.wdata[7];
				end
				TEST_ADDR: begin
					ctrl_q.test_mode <= bus.wdata[0];
				end
				default: begin
					// unmapped, write dropped
				end
			endcase
		end
	end

	assign pad_ctrl = ctrl_q;

	// p15 in bit 5, p14 in bit 4
	assign p1_view   = {P1_HI_ONES, ctrl_q.sel, col_sync};
	assign test_view = {TEST_HI_ONES, ctrl_q.test_mode};

	always_comb begin
		case (bus.addr)
			P1_ADDR:   bus.rdata = p1_view;
			TEST_ADDR: bus.rdata = test_view;
			default:   bus.rdata = OPEN_BUS_DATA;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/joypad_matrix.sv */
`default_nettype none

module joypad_matrix
	import joypad_pkg::*;
	(
		input  logic      clk,
		input  logic      rst_n,

		input  pad_ctrl_t pad_ctrl,

		input  col_t      p1_in,
		input  logic      ser_out,

		output logic      p14,
		output logic      p15,
		output col_t      p1_out,
		output col_t      p1_oe,
		output logic      sout,
		output logic      sin_out,
		output logic      sin_oe,

		output col_t      col_sync,
		output logic      joypad_irq
	);

	col_t sync_q [SYNC_STAGES];
	col_t col_prev;
	col_t col_fall;
	logic test_mode;

	assign test_mode = pad_ctrl.test_mode;

	// row drive, active low
	assign p14 = pad_ctrl.sel[0];
	assign p15 = pad_ctrl.sel[1];

	// pins are asynchronous to clk
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < SYNC_STAGES; i++)
				sync_q[i] <= COLS_IDLE;
		end else begin
			sync_q[0] <= p1_in;
			for (int i = 1; i < SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	assign col_sync = sync_q[SYNC_STAGES-1];

	// falling column edge = key went down
	assign col_fall = col_prev & ~col_sync;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_prev   <= COLS_IDLE;
			joypad_irq <= 1'b0;
		end else begin
			col_prev   <= col_sync;
			joypad_irq <= (|col_fall) && !test_mode; // masked in test mode
		end
	end

	// test mode takes over the column and serial pins
	assign p1_out  = test_mode ? pad_ctrl.test_cols : COLS_IDLE;
	assign p1_oe   = {COL_W{test_mode}};
	assign sin_out = pad_ctrl.test_sin;
	assign sin_oe  = test_mode;
	assign sout    = test_mode ? pad_ctrl.test_sout : ser_out;

endmodule

`default_nettype wire

/* verilog/joypad_io_top.sv */
`default_nettype none

module joypad_io_top
	import io_bus_pkg::*;
	import joypad_pkg::*;
	(
		input  logic  clk,
		input  logic  rst_n,

		// cpu side
		input  logic  req,
		input  logic  we,
		input  addr_t addr,
		input  data_t wdata,
		output logic  ack,
		output data_t rdata,

		// pad pins
		output logic  p14,
		output logic  p15,
		input  col_t  p1_in,
		output col_t  p1_out,
		output col_t  p1_oe,

		// serial pins
		input  logic  ser_out,
		output logic  sout,
		output logic  sin_out,
		output logic  sin_oe,

		output logic  joypad_irq
	);

	io_bus_if  bus0 ();
	pad_ctrl_t pad_ctrl;
	col_t      col_sync;

	io_bus_slave slave0 (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.we    (we),
		.addr  (addr),
		.wdata (wdata),
		.ack   (ack),
		.rdata (rdata),
		.bus   (bus0.slave)
	);

	joypad_regs regs0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.bus      (bus0.target),
		.col_sync (col_sync),
		.pad_ctrl (pad_ctrl)
	);

	joypad_matrix matrix0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.pad_ctrl   (pad_ctrl),
		.p1_in      (p1_in),
		.ser_out    (ser_out),
		.p14        (p14),
		.p15        (p15),
		.p1_out     (p1_out),
		.p1_oe      (p1_oe),
		.sout       (sout),
		.sin_out    (sin_out),
		.sin_oe     (sin_oe),
		.col_sync   (col_sync),
		.joypad_irq (joypad_irq)
	);

endmodule

`default_nettype wire

/* verif/tb_joypad_io.sv */
`default_nettype none

module tb_joypad_io
	import io_bus_pkg::*;
	import joypad_pkg::*;
	();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS = 6;
	localparam int ACK_LIMIT = 20;              // negedges before giving up on ack
	localparam int SETTLE    = SYNC_STAGES + 4; // model flop, sync, edge detect
	localparam int RISE_WAIT = 3;               // drive edge plus two slave edges
	localparam int FALL_WAIT = 2;

	logic  clk;
	logic  rst_n;
	logic  req;
	logic  we;
	logic  ack;
	addr_t addr;
	data_t wdata;
	data_t rdata;
	logic  p14;
	logic  p15;
	col_t  p1_in;
	col_t  p1_out;
	col_t  p1_oe;
	logic  ser_out;
	logic  sout;
	logic  sin_out;
	logic  sin_oe;
	logic  joypad_irq;

	logic [7:0]  keys; // 3:0 directions, 7:4 buttons
	logic [31:0] rng;
	logic        ack_prev;
	int          irq_count;
	int          data_errors;
	int          col_errors;
	int          bit_errors;
	int          other_errors;

	joypad_io_top dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.we         (we),
		.addr       (addr),
		.wdata      (wdata),
		.ack        (ack),
		.rdata      (rdata),
		.p14        (p14),
		.p15        (p15),
		.p1_in      (p1_in),
		.p1_out     (p1_out),
		.p1_oe      (p1_oe),
		.ser_out    (ser_out),
		.sout       (sout),
		.sin_out    (sin_out),
		.sin_oe     (sin_oe),
		.joypad_irq (joypad_irq)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// a column is pulled low by any pressed key in a driven row
	function automatic col_t expected_cols(input logic [7:0] k, input sel_t s);
		col_t c;
		for (int i = 0; i < COL_W; i++)
			c[i] = !((k[i] && !s[0]) || (k[i+4] && !s[1]));
		return c;
	endfunction

	always @(posedge clk)
		p1_in <= expected_cols(keys, {p15, p14}); // key matrix

	always @(negedge clk) begin
		if (joypad_irq === 1'b1)
			irq_count++;
		if (rst_n && ack && !ack_prev && !req) begin
			$display("ack rose at %0t while req was low", $time);
			other_errors++;
		end
		ack_prev = ack;
	end

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			data_errors++;
		end
	endtask

	task automatic check_cols(input string name, input col_t got, input col_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			col_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			bit_errors++;
		end
	endtask

	task automatic bus_access(input logic wr, input addr_t a, input data_t d, input int hold,
			output data_t rd, output int rise, output int fall);
		int n;
		@(posedge clk);
		req   <= 1'b1;
		we    <= wr;
		addr  <= a;
		wdata <= d;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (ack !== 1'b1 && n < ACK_LIMIT);
		rise = n;
		if (ack !== 1'b1) begin
			$display("bus slave gave no ack for address 0x%h", a);
			other_errors++;
		end
		rd = rdata;
		repeat (hold) begin // master keeps req high
			@(negedge clk);
			check_bit("ack", ack, 1'b1);
			check_data("rdata", rdata, rd);
		end
		@(posedge clk);
		req <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (ack !== 1'b0 && n < ACK_LIMIT);
		fall = n;
		if (ack !== 1'b0) begin
			$display("ack stayed high after req was dropped");
			other_errors++;
		end
	endtask

	task automatic bus_write(input addr_t a, input data_t d);
		data_t rd;
		int    rise;
		int    fall;
		bus_access(1'b1, a, d, 0, rd, rise, fall);
	endtask

	task automatic bus_read(input addr_t a, output data_t d);
		int rise;
		int fall;
		bus_access(1'b0, a, 8'h00, 0, d, rise, fall);
	endtask

	task automatic set_keys(input logic [7:0] k);
		@(posedge clk);
		keys <= k;
	endtask

	task automatic set_ser(input logic b);
		@(posedge clk);
		ser_out <= b;
	endtask

	task automatic settle();
		repeat (SETTLE) @(negedge clk);
	endtask

	task automatic reset_values();
		data_t d;
		bus_read(P1_ADDR, d);
		check_data("p1", d, 8'hff); // no row selected, no key
		bus_read(TEST_ADDR, d);
		check_data("test_reg", d, 8'hfe);
		@(negedge clk);
		check_bit("p14", p14, 1'b1);
		check_bit("p15", p15, 1'b1);
		check_cols("p1_oe", p1_oe, 4'h0);
		check_bit("sin_oe", sin_oe, 1'b0);
		for (int b = 1; b >= 0; b--) begin
			set_ser(b[0]);
			@(negedge clk);
			check_bit("sout", sout, b[0]);
		end
	endtask

	task automatic key_matrix_scan();
		logic [31:0] r;
		logic [7:0]  k;
		sel_t        s;
		data_t       d;
		for (int n = 0; n < 6; n++) begin
			r = next_rand();
			k = r[7:0];
			set_keys(k);
			for (int j = 0; j < 4; j++) begin
				s = sel_t'(j);
				bus_write(P1_ADDR, {2'b00, s, 4'h0});
				settle();
				bus_read(P1_ADDR, d);
				check_cols("p1[3:0]", d[3:0], expected_cols(k, s));
				check_data("p1[7:4]", {d[7:4], 4'h0}, {2'b11, s, 4'h0});
			end
		end
	endtask

	task automatic open_bus_space();
		logic [31:0] r;
		addr_t       a;
		data_t       d;
		data_t       p1_exp;
		data_t       test_exp;
		set_keys(8'h00);
		bus_write(P1_ADDR, 8'h20); // directions row
		settle();
		p1_exp   = {2'b11, 2'b10, 4'hf}; // no key down
		test_exp = 8'hfe;
		for (int n = 0; n < 8; n++) begin
			r = next_rand();
			a = r[7:0];
			if (a == P1_ADDR || a == TEST_ADDR)
				a = a ^ 8'h01;
			bus_read(a, d);
			check_data("open bus", d, OPEN_BUS_DATA);
			bus_write(a, r[15:8]);
			bus_read(P1_ADDR, d);
			check_data("p1", d, p1_exp);
			bus_read(TEST_ADDR, d);
			check_data("test_reg", d, test_exp);
		end
	endtask

	task automatic pin_test_mode();
		logic [31:0] r;
		data_t       d;
		bus_write(TEST_ADDR, 8'h01);
		for (int n = 0; n < 8; n++) begin
			r = next_rand();
			d = r[7:0];
			set_ser(r[8]); // must not reach sout
			bus_write(P1_ADDR, d);
			@(negedge clk);
			check_cols("p1_out", p1_out, d[3:0]);
			check_cols("p1_oe", p1_oe, 4'hf);
			check_bit("sout", sout, d[6]);
			check_bit("sin_out", sin_out, d[7]);
			check_bit("sin_oe", sin_oe, 1'b1);
		end
		bus_write(TEST_ADDR, 8'h00);
		for (int b = 0; b < 2; b++) begin
			set_ser(b[0]);
			@(negedge clk);
			check_bit("sout", sout, b[0]);
			check_cols("p1_oe", p1_oe, 4'h0);
			check_bit("sin_oe", sin_oe, 1'b0);
		end
	endtask

	task automatic irq_edges();
		int base;
		set_keys(8'h00);
		bus_write(P1_ADDR, 8'h20);
		settle();
		base = irq_count;
		set_keys(8'h01); // right key in the selected row
		settle();
		check_data("joypad_irq pulses on press", data_t'(irq_count - base), 8'd1);
		base = irq_count;
		set_keys(8'h00);
		settle();
		check_data("joypad_irq pulses on release", data_t'(irq_count - base), 8'd0);
		base = irq_count;
		set_keys(8'h10); // button row not driven
		settle();
		check_data("joypad_irq pulses, unselected row", data_t'(irq_count - base), 8'd0);
		set_keys(8'h00);
		bus_write(TEST_ADDR, 8'h01);
		settle();
		base = irq_count;
		set_keys(8'h02);
		settle();
		check_data("joypad_irq pulses in test mode", data_t'(irq_count - base), 8'd0);
		set_keys(8'h00);
		settle();
		bus_write(TEST_ADDR, 8'h00);
		settle();
	endtask

	task automatic handshake_hold();
		logic [31:0] r;
		addr_t       a;
		data_t       rd;
		int          hold;
		int          rise;
		int          fall;
		set_keys(8'h00);
		bus_write(P1_ADDR, 8'h10); // buttons row
		settle();
		for (int n = 0; n < 4; n++) begin
			r = next_rand();
			hold = int'(r[2:0]) + 1;
			a = r[3] ? P1_ADDR : TEST_ADDR;
			fork
				bus_access(1'b0, a, 8'h00, hold, rd, rise, fall);
				set_keys(8'hf0); // columns fall while ack is held
			join
			check_data("ack rise wait", data_t'(rise), data_t'(RISE_WAIT));
			check_data("ack fall wait", data_t'(fall), data_t'(FALL_WAIT));
			check_data("rdata", rd, r[3] ? {2'b11, 2'b01, 4'hf} : 8'hfe);
			set_keys(8'h00);
			settle();
		end
	endtask

	initial begin
		rst_n        = 1'b0;
		req          = 1'b0;
		we           = 1'b0;
		addr         = '0;
		wdata        = '0;
		ser_out      = 1'b0;
		p1_in        = 4'hf;
		keys         = '0;
		rng          = 32'd42275;
		ack_prev     = 1'b0;
		irq_count    = 0;
		data_errors  = 0;
		col_errors   = 0;
		bit_errors   = 0;
		other_errors = 0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		reset_values();
		key_matrix_scan();
		open_bus_space();
		pin_test_mode();
		irq_edges();
		handshake_hold();
		$display("errors: data %0d, cols %0d, bit %0d, other %0d",
			data_errors, col_errors, bit_errors, other_errors);
		if (data_errors + col_errors + bit_errors + other_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		repeat (NUM_TESTS * 2000) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
verilog/io_bus_pkg.sv
verilog/joypad_pkg.sv
verilog/io_bus_if.sv
verilog/io_bus_slave.sv
verilog/joypad_regs.sv
verilog/joypad_matrix.sv
verilog/joypad_io_top.sv
verif/tb_joypad_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the joypad I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_joypad_io -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out="$(./obj_dir/Vtb_joypad_io)"
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
